// File: logic/commit_stage.sv
// commit stage that retires the finished head entry and drives the registered commit bus
`timescale 1ns/100ps
`default_nettype none

module commit_stage (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           flush,
	input  wire                           head_ready,
	input  wire [ooo_pkg::tag_bits-1:0]   head_tag,
	input  wire [ooo_pkg::areg_bits-1:0]  head_rd,
	input  wire                           head_rfw,
	input  wire                           head_srw,
	output logic                          retire,
	output logic                          commit_v,
	output logic [ooo_pkg::tag_bits-1:0]  commit_id,
	output logic [ooo_pkg::areg_bits-1:0] commit_rd,
	output logic                          commit_rfw,
	output logic                          commit_srw
);

	// at most one entry leaves per cycle and only from the head,
	// which keeps retirement in program order
	// nothing retires while a flush is discarding the buffer
	assign retire = head_ready & ~flush;

	// the commit strobe is a single-cycle pulse after each retiring edge
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			commit_v <= 1'b0;
		end else begin
			commit_v <= retire;
		end
	end

	// the head fields are captured on the same edge that pops the entry
	always_ff @(posedge clk) begin
		if (retire) begin
			commit_id  <= head_tag;
			commit_rd  <= head_rd;
			commit_rfw <= head_rfw;
			commit_srw <= head_srw;
		end
	end

endmodule

`default_nettype wire

// File: logic/dispatch_tagger.sv
// dispatch stage that accepts one instruction per cycle, tags it and tracks youngest writers
`timescale 1ns/100ps
`default_nettype none

module dispatch_tagger (
	input  wire                                                 clk,
	input  wire                                                 rst,
	input  wire                                                 flush,
	input  wire                                                 issue_v,
	input  wire                                                 issue_rfw,
	input  wire [ooo_pkg::areg_bits-1:0]                        issue_rd,
	input  wire                                                 issue_srw,
	input  wire [ooo_pkg::tag_bits-1:0]                         tail_tag,
	input  wire                                                 full,
	output logic                                                issue_ready,
	output logic                                                alloc_v,
	output logic [ooo_pkg::tag_bits-1:0]                        alloc_tag,
	output logic [ooo_pkg::areg_bits-1:0]                       alloc_rd,
	output logic                                                alloc_rfw,
	output logic                                                alloc_srw,
	output logic [ooo_pkg::areg_count-1:0][ooo_pkg::tag_bits-1:0] rf_source,
	output logic [ooo_pkg::tag_bits-1:0]                        sr_source
);

	// ==========================================================
	// acceptance
	// ==========================================================

	// an instruction may enter while the buffer has a free entry
	// and no branch-miss flush is being taken this cycle
	assign issue_ready = ~full & ~flush;

	// the allocate strobe only fires on the accepting edge
	assign alloc_v = issue_v & issue_ready;

	// a new entry always lands at the buffer tail, so the tail pointer is its tag
	assign alloc_tag = tail_tag;
	assign alloc_rd  = issue_rd;
	assign alloc_rfw = issue_rfw;
	assign alloc_srw = issue_srw;

	// ==========================================================
	// youngest-writer table
	// ==========================================================

	// every register remembers the tag of the last dispatched instruction
	// that writes it, and the status register has one slot of its own
	// a retiring writer validates its target only while its tag is still here
	always_ff @(posedge clk) begin
		if (rst) begin
			rf_source <= '0;
			sr_source <= '0;
		end else begin
			if (alloc_v && issue_rfw) begin
				rf_source[issue_rd] <= alloc_tag;
			end
			// status writes are tracked independently of the register write
			if (alloc_v && issue_srw) begin
				sr_source <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/ooo_pkg.sv
// shared widths and depths of the reorder-buffer core, referenced by scoped name from each block
`default_nettype none

package ooo_pkg;

	// ==========================================================
	// architectural registers
	// ==========================================================

	// general purpose registers tracked by the scoreboard
	localparam int areg_count = 8;

	// width of a general register index
	localparam int areg_bits = 3;

	// the status register bit sits just above the last general register
	localparam int sr_index = areg_count;

	// ==========================================================
	// reorder buffer
	// ==========================================================

	// number of in-flight entries, each one named by its own tag
	localparam int rob_depth = 8;

	// width of a tag, wide enough to name every entry
	localparam int tag_bits = 3;

endpackage

`default_nettype wire

// File: logic/reg_valid_tracker.sv
// scoreboard of register and status valid bits, with a look-ahead vector for read-through
`timescale 1ns/100ps
`default_nettype none

module reg_valid_tracker (
	input  wire                                                 clk,
	input  wire                                                 rst,
	input  wire                                                 flush,
	input  wire                                                 alloc_v,
	input  wire [ooo_pkg::areg_bits-1:0]                        alloc_rd,
	input  wire                                                 alloc_rfw,
	input  wire                                                 alloc_srw,
	input  wire                                                 commit_v,
	input  wire [ooo_pkg::tag_bits-1:0]                         commit_id,
	input  wire [ooo_pkg::areg_bits-1:0]                        commit_rd,
	input  wire                                                 commit_rfw,
	input  wire                                                 commit_srw,
	input  wire [ooo_pkg::areg_count-1:0][ooo_pkg::tag_bits-1:0] rf_source,
	input  wire [ooo_pkg::tag_bits-1:0]                         sr_source,
	output logic [ooo_pkg::sr_index:0]                          rf_v,
	output logic [ooo_pkg::sr_index:0]                          reg_is_valid
);

	// bits forced valid by a branch-miss flush
	logic [ooo_pkg::sr_index:0] flush_set;

	// bits validated by the instruction on the commit bus
	logic [ooo_pkg::sr_index:0] commit_set;

	// bits invalidated by the instruction being dispatched
	logic [ooo_pkg::sr_index:0] alloc_clr;

	// the committing instruction is still the youngest writer of its target
	logic commit_rf_hit;
	logic commit_sr_hit;

	// ==========================================================
	// flush
	// ==========================================================

	// every in-flight entry is discarded, so no register is pending any more
	assign flush_set = {(ooo_pkg::sr_index+1){flush}};

	// ==========================================================
	// commit validation
	// ==========================================================

	// the pending tag may have moved on to a younger writer since this
	// instruction was dispatched, in which case the register stays invalid
	// until that younger writer commits
	assign commit_rf_hit = commit_v & commit_rfw & (rf_source[commit_rd] == commit_id);

	// the status register follows the same youngest-writer rule
	assign commit_sr_hit = commit_v & commit_srw & (sr_source == commit_id);

	always_comb begin
		commit_set = '0;
		if (commit_rf_hit) begin
			commit_set[commit_rd] = 1'b1;
		end
		if (commit_sr_hit) begin
			commit_set[ooo_pkg::sr_index] = 1'b1;
		end
	end

	// ==========================================================
	// dispatch invalidation
	// ==========================================================

	// a dispatched writer makes its target pending from the next cycle on
	always_comb begin
		alloc_clr = '0;
		if (alloc_v && alloc_rfw) begin
			alloc_clr[alloc_rd] = 1'b1;
		end
		if (alloc_v && alloc_srw) begin
			alloc_clr[ooo_pkg::sr_index] = 1'b1;
		end
	end

	// ==========================================================
	// valid bits
	// ==========================================================

	// the look-ahead vector is what rf_v holds after the coming edge,
	// letting a read-through register file see a result a cycle early
	// setting bits by OR leaves an already valid bit untouched, and the
	// dispatch clear is applied last so it beats a commit to the same register
	assign reg_is_valid = (rf_v | flush_set | commit_set) & ~alloc_clr;

	// out of reset nothing is pending
	always_ff @(posedge clk) begin
		if (rst) begin
			rf_v <= '1;
		end else begin
			rf_v <= reg_is_valid;
		end
	end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
// circular reorder buffer holding in-flight entries, marking completions and exposing the head
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           flush,
	input  wire                           alloc_v,
	input  wire [ooo_pkg::areg_bits-1:0]  alloc_rd,
	input  wire                           alloc_rfw,
	input  wire                           alloc_srw,
	input  wire                           done_v,
	input  wire [ooo_pkg::tag_bits-1:0]   done_id,
	input  wire                           retire,
	output logic [ooo_pkg::tag_bits-1:0]  tail_tag,
	output logic                          full,
	output logic                          head_ready,
	output logic [ooo_pkg::tag_bits-1:0]  head_tag,
	output logic [ooo_pkg::areg_bits-1:0] head_rd,
	output logic                          head_rfw,
	output logic                          head_srw
);

	// per-entry status bits, indexed by tag
	logic [ooo_pkg::rob_depth-1:0] ent_v;
	logic [ooo_pkg::rob_depth-1:0] ent_done;

	// per-entry payload, written on allocate and only read while valid
	logic [ooo_pkg::areg_bits-1:0] ent_rd [ooo_pkg::rob_depth];
	logic [ooo_pkg::rob_depth-1:0] ent_rfw;
	logic [ooo_pkg::rob_depth-1:0] ent_srw;

	// oldest entry, next free entry and number of entries in flight
	logic [ooo_pkg::tag_bits-1:0] head;
	logic [ooo_pkg::tag_bits-1:0] tail;
	logic [ooo_pkg::tag_bits:0]   count;

	// completions naming an entry that is not in flight are dropped
	logic do_done;

	assign do_done = done_v & ent_v[done_id];

	// ==========================================================
	// status outputs
	// ==========================================================

	assign tail_tag = tail;
	assign full     = (count == (ooo_pkg::tag_bits+1)'(ooo_pkg::rob_depth));

	// the head can retire once it holds a finished instruction
	assign head_ready = ent_v[head] & ent_done[head];
	assign head_tag   = head;
	assign head_rd    = ent_rd[head];
	assign head_rfw   = ent_rfw[head];
	assign head_srw   = ent_srw[head];

	// ==========================================================
	// entry state and pointers
	// ==========================================================

	// a flush throws away every entry, so it empties the buffer like reset
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ent_v    <= '0;
			ent_done <= '0;
			head     <= '0;
			tail     <= '0;
			count    <= '0;
		end else begin
			if (do_done) begin
				ent_done[done_id] <= 1'b1;
			end
			// the tail entry is free, so it never collides with done marking
			if (alloc_v) begin
				ent_v[tail]    <= 1'b1;
				ent_done[tail] <= 1'b0;
				tail           <= tail + 1'b1;
			end
			if (retire) begin
				ent_v[head] <= 1'b0;
				head        <= head + 1'b1;
			end
			// allocate and retire in the same cycle leave the count as it is
			case ({alloc_v, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// payload capture at the tail
	always_ff @(posedge clk) begin
		if (alloc_v) begin
			ent_rd[tail]  <= alloc_rd;
			ent_rfw[tail] <= alloc_rfw;
			ent_srw[tail] <= alloc_srw;
		end
	end

endmodule

`default_nettype wire

// File: logic/rob_core_top.sv
// top level of the reorder-buffer scoreboard core, wiring dispatch, buffer, commit and tracker
`timescale 1ns/100ps
`default_nettype none

module rob_core_top (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           flush,
	input  wire                           issue_v,
	input  wire                           issue_rfw,
	input  wire [ooo_pkg::areg_bits-1:0]  issue_rd,
	input  wire                           issue_srw,
	input  wire                           done_v,
	input  wire [ooo_pkg::tag_bits-1:0]   done_id,
	output logic                          issue_ready,
	output logic                          commit_v,
	output logic [ooo_pkg::tag_bits-1:0]  commit_id,
	output logic [ooo_pkg::areg_bits-1:0] commit_rd,
	output logic [ooo_pkg::sr_index:0]    rf_v,
	output logic [ooo_pkg::sr_index:0]    reg_is_valid
);

	// dispatch to buffer and tracker
	logic                                                 alloc_v;
	logic [ooo_pkg::areg_bits-1:0]                        alloc_rd;
	logic                                                 alloc_rfw;
	logic                                                 alloc_srw;
	logic [ooo_pkg::areg_count-1:0][ooo_pkg::tag_bits-1:0] rf_source;
	logic [ooo_pkg::tag_bits-1:0]                         sr_source;

	// buffer back to dispatch, and buffer head to commit
	logic [ooo_pkg::tag_bits-1:0]  tail_tag;
	logic                          full;
	logic                          head_ready;
	logic [ooo_pkg::tag_bits-1:0]  head_tag;
	logic [ooo_pkg::areg_bits-1:0] head_rd;
	logic                          head_rfw;
	logic                          head_srw;
	logic                          retire;

	// commit bus write flags, only needed by the tracker
	logic commit_rfw;
	logic commit_srw;

	dispatch_tagger u_dispatch (
		.clk(clk), .rst(rst), .flush(flush),
		.issue_v(issue_v), .issue_rfw(issue_rfw), .issue_rd(issue_rd), .issue_srw(issue_srw),
		.tail_tag(tail_tag), .full(full), .issue_ready(issue_ready),
		.alloc_v(alloc_v), .alloc_tag(), .alloc_rd(alloc_rd),
		.alloc_rfw(alloc_rfw), .alloc_srw(alloc_srw),
		.rf_source(rf_source), .sr_source(sr_source)
	);

	reorder_buffer u_rob (
		.clk(clk), .rst(rst), .flush(flush),
		.alloc_v(alloc_v), .alloc_rd(alloc_rd), .alloc_rfw(alloc_rfw), .alloc_srw(alloc_srw),
		.done_v(done_v), .done_id(done_id), .retire(retire),
		.tail_tag(tail_tag), .full(full), .head_ready(head_ready), .head_tag(head_tag),
		.head_rd(head_rd), .head_rfw(head_rfw), .head_srw(head_srw)
	);

	commit_stage u_commit (
		.clk(clk), .rst(rst), .flush(flush),
		.head_ready(head_ready), .head_tag(head_tag), .head_rd(head_rd),
		.head_rfw(head_rfw), .head_srw(head_srw), .retire(retire),
		.commit_v(commit_v), .commit_id(commit_id), .commit_rd(commit_rd),
		.commit_rfw(commit_rfw), .commit_srw(commit_srw)
	);

	reg_valid_tracker u_tracker (
		.clk(clk), .rst(rst), .flush(flush),
		.alloc_v(alloc_v), .alloc_rd(alloc_rd), .alloc_rfw(alloc_rfw), .alloc_srw(alloc_srw),
		.commit_v(commit_v), .commit_id(commit_id), .commit_rd(commit_rd),
		.commit_rfw(commit_rfw), .commit_srw(commit_srw),
		.rf_source(rf_source), .sr_source(sr_source),
		.rf_v(rf_v), .reg_is_valid(reg_is_valid)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the reorder-buffer testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rob_core -f tb.f -o sim_rob_core \
	> build.log 2>&1 \
	&& ./obj_dir/sim_rob_core > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb.f
logic/ooo_pkg.sv
logic/dispatch_tagger.sv
logic/reorder_buffer.sv
logic/commit_stage.sv
logic/reg_valid_tracker.sv
logic/rob_core_top.sv
verif/tb_rob_core.sv

// File: verif/tb_rob_core.sv
// testbench for the reorder-buffer scoreboard core, run from tb.f with a reference model and assertions
`timescale 1ns/100ps
`default_nettype none

module tb_rob_core;

	logic                          clk;
	logic                          rst;
	logic                          flush;
	logic                          issue_v;
	logic                          issue_rfw;
	logic [ooo_pkg::areg_bits-1:0] issue_rd;
	logic                          issue_srw;
	logic                          done_v;
	logic [ooo_pkg::tag_bits-1:0]  done_id;
	wire                           issue_ready;
	wire                           commit_v;
	wire  [ooo_pkg::tag_bits-1:0]  commit_id;
	wire  [ooo_pkg::areg_bits-1:0] commit_rd;
	wire  [ooo_pkg::sr_index:0]    rf_v;
	wire  [ooo_pkg::sr_index:0]    reg_is_valid;

	// the reference model keeps valid bits, youngest writers and in-flight tags in program order
	logic [ooo_pkg::sr_index:0]    m_v;
	logic [ooo_pkg::tag_bits-1:0]  m_src [ooo_pkg::areg_count];
	logic [ooo_pkg::tag_bits-1:0]  m_sr_src;
	logic [ooo_pkg::tag_bits-1:0]  m_q [$];
	logic                          m_done [ooo_pkg::rob_depth];
	logic [ooo_pkg::areg_bits-1:0] m_rd [ooo_pkg::rob_depth];
	logic                          m_rfw [ooo_pkg::rob_depth];
	logic                          m_srw [ooo_pkg::rob_depth];
	logic [ooo_pkg::tag_bits-1:0]  m_tail;
	int                            m_count;

	// the entry expected on the commit bus in the current cycle
	logic                          m_pend_v;
	logic [ooo_pkg::tag_bits-1:0]  m_pend_tag;
	logic [ooo_pkg::areg_bits-1:0] m_pend_rd;
	logic                          m_pend_rfw;
	logic                          m_pend_srw;

	// bookkeeping for reporting and the run limit
	string test_name = "reset";
	int    errors = 0;
	int    test_err_start = 0;
	int    tests_run = 0;
	int    commit_count = 0;
	int    cycles = 0;
	int    max_cycles = 600;

	logic [ooo_pkg::tag_bits-1:0] tags [9];
	int                           order [6];

	rob_core_top DUT (
		.clk(clk), .rst(rst), .flush(flush),
		.issue_v(issue_v), .issue_rfw(issue_rfw), .issue_rd(issue_rd), .issue_srw(issue_srw),
		.done_v(done_v), .done_id(done_id), .issue_ready(issue_ready),
		.commit_v(commit_v), .commit_id(commit_id), .commit_rd(commit_rd),
		.rf_v(rf_v), .reg_is_valid(reg_is_valid)
	);

	always #20 clk = ~clk;

	// ============================================================
	// reference model
	// ============================================================

	// one step per rising edge; a commit seen on the bus validates its target only
	// while it is still the youngest writer, and a dispatch in the same cycle wins
	always @(posedge clk) begin
		logic                         accept;
		logic [ooo_pkg::tag_bits-1:0] head;
		accept = issue_v && (m_count < ooo_pkg::rob_depth) && !flush;
		if (rst || flush) begin
			m_v = '1;
			m_q.delete();
			m_count = 0;
			m_tail = '0;
			m_pend_v = 1'b0;
			if (rst) begin
				foreach (m_src[i]) m_src[i] = '0;
				m_sr_src = '0;
			end
		end else begin
			if (m_pend_v && m_pend_rfw && m_src[m_pend_rd] == m_pend_tag)
				m_v[m_pend_rd] = 1'b1;
			if (m_pend_v && m_pend_srw && m_sr_src == m_pend_tag)
				m_v[ooo_pkg::sr_index] = 1'b1;
			// the oldest entry retires once it was already marked done before this edge
			m_pend_v = 1'b0;
			if (m_q.size() > 0 && m_done[m_q[0]]) begin
				head = m_q.pop_front();
				m_pend_v = 1'b1;
				m_pend_tag = head;
				m_pend_rd = m_rd[head];
				m_pend_rfw = m_rfw[head];
				m_pend_srw = m_srw[head];
				m_count = m_count - 1;
			end
			// a done strobe only counts for a tag that is still in flight
			if (done_v) begin
				foreach (m_q[i]) if (m_q[i] == done_id) m_done[done_id] = 1'b1;
			end
			if (accept) begin
				if (issue_rfw) begin
					m_v[issue_rd] = 1'b0;
					m_src[issue_rd] = m_tail;
				end
				if (issue_srw) begin
					m_v[ooo_pkg::sr_index] = 1'b0;
					m_sr_src = m_tail;
				end
				m_rd[m_tail] = issue_rd;
				m_rfw[m_tail] = issue_rfw;
				m_srw[m_tail] = issue_srw;
				m_done[m_tail] = 1'b0;
				m_q.push_back(m_tail);
				m_tail = m_tail + (ooo_pkg::tag_bits)'(1);
				m_count = m_count + 1;
			end
		end
	end

	// ============================================================
	// assertions
	// ============================================================

	a_valid_bits: assert property (@(posedge clk) disable iff (rst) rf_v == m_v)
		else begin
			$display("ERROR %s: rf_v expected %h actual %h", test_name, $sampled(m_v),
				$sampled(rf_v));
			errors++;
		end

	// the look-ahead vector of one cycle must equal the valid bits the model holds in the next
	a_look_ahead: assert property (@(posedge clk) disable iff (rst)
		$past(reg_is_valid) == m_v)
		else begin
			$display("ERROR %s: reg_is_valid expected %h actual %h", test_name,
				$sampled(m_v), $past(reg_is_valid));
			errors++;
		end

	a_ready: assert property (@(posedge clk) disable iff (rst)
		issue_ready == (m_count < ooo_pkg::rob_depth && !flush))
		else begin
			$display("ERROR %s: issue_ready expected %b actual %b", test_name,
				$sampled(m_count < ooo_pkg::rob_depth && !flush), $sampled(issue_ready));
			errors++;
		end

	a_commit_strobe: assert property (@(posedge clk) disable iff (rst) commit_v == m_pend_v)
		else begin
			$display("ERROR %s: commit_v expected %b actual %b", test_name,
				$sampled(m_pend_v), $sampled(commit_v));
			errors++;
		end

	// commits leave in dispatch order, so the bus must name the model's oldest entry
	a_commit_fields: assert property (@(posedge clk) disable iff (rst)
		!commit_v || (commit_id == m_pend_tag && commit_rd == m_pend_rd))
		else begin
			$display("ERROR %s: commit id/rd expected %h/%h actual %h/%h", test_name,
				$sampled(m_pend_tag), $sampled(m_pend_rd), $sampled(commit_id),
				$sampled(commit_rd));
			errors++;
		end

	always @(negedge clk) begin
		if (!rst && commit_v) commit_count++;
	end

	// the run is cut off at a cycle limit well above the length of all tests
	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ============================================================
	// stimulus tasks
	// ============================================================

	// every task starts and ends 2 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err_start = errors;
	endtask

	task automatic end_test();
		$display("test %s finished with %0d errors", test_name, errors - test_err_start);
		tests_run++;
	endtask

	task automatic check_value(input string what, input int unsigned exp, input int unsigned act);
		assert (exp == act)
			else begin
				$display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
				errors++;
			end
	endtask

	// holds the instruction until the DUT shows issue_ready before an edge
	task automatic issue(input logic rfw, input logic [ooo_pkg::areg_bits-1:0] rd,
		input logic srw, output logic [ooo_pkg::tag_bits-1:0] tag);
		logic ok;
		issue_v = 1'b1;
		issue_rfw = rfw;
		issue_rd = rd;
		issue_srw = srw;
		ok = 1'b0;
		while (!ok) begin
			@(negedge clk);
			ok = issue_ready;
			tag = m_tail;
			next_cycle();
		end
		issue_v = 1'b0;
		issue_rfw = 1'b0;
		issue_rd = '0;
		issue_srw = 1'b0;
	endtask

	task automatic complete(input logic [ooo_pkg::tag_bits-1:0] tag);
		done_v = 1'b1;
		done_id = tag;
		next_cycle();
		done_v = 1'b0;
		done_id = '0;
	endtask

	// returns after the edge that applied the last awaited commit to the scoreboard
	task automatic wait_commit_total(input int target);
		while (commit_count < target) next_cycle();
	endtask

	// ============================================================
	// tests
	// ============================================================

	task automatic after_reset();
		start_test("reset_state");
		@(negedge clk);
		check_value("rf_v", (1 << (ooo_pkg::sr_index + 1)) - 1, 32'(rf_v));
		check_value("issue_ready", 1, 32'(issue_ready));
		check_value("commit_v", 0, 32'(commit_v));
		next_cycle();
		end_test();
	endtask

	task automatic dispatch_clears_targets();
		int base;
		start_test("dispatch_clear");
		base = commit_count;
		issue(1'b1, 3'd2, 1'b0, tags[0]);
		issue(1'b0, 3'd0, 1'b1, tags[1]);
		// register 2 and the status bit are now pending
		check_value("rf_v", 32'h0fb, 32'(rf_v));
		issue(1'b0, 3'd5, 1'b0, tags[2]);
		check_value("rf_v", 32'h0fb, 32'(rf_v));
		for (int i = 0; i < 3; i++) complete(tags[i]);
		wait_commit_total(base + 3);
		end_test();
	endtask

	task automatic random_completion();
		int base;
		int j;
		int t;
		start_test("random_order");
		base = commit_count;
		for (int i = 0; i < 6; i++) begin
			issue(1'b1, 3'(i), i == 2, tags[i]);
			order[i] = i;
		end
		// shuffle the completion order
		for (int i = 5; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < 6; i++) complete(tags[order[i]]);
		wait_commit_total(base + 6);
		end_test();
	endtask

	task automatic youngest_writer_rule();
		int base;
		start_test("youngest_writer");
		base = commit_count;
		issue(1'b1, 3'd3, 1'b1, tags[0]);
		issue(1'b1, 3'd3, 1'b1, tags[1]);
		complete(tags[0]);
		wait_commit_total(base + 1);
		// the older writer has retired but a younger one is still pending
		check_value("rf_v[3]", 0, 32'(rf_v[3]));
		check_value("status bit", 0, 32'(rf_v[ooo_pkg::sr_index]));
		complete(tags[1]);
		wait_commit_total(base + 2);
		check_value("rf_v[3]", 1, 32'(rf_v[3]));
		check_value("status bit", 1, 32'(rf_v[ooo_pkg::sr_index]));
		end_test();
	endtask

	task automatic full_buffer_stall();
		int base;
		start_test("back_pressure");
		base = commit_count;
		for (int i = 0; i < ooo_pkg::rob_depth; i++) issue(1'b1, 3'(i), 1'b0, tags[i]);
		@(negedge clk);
		check_value("issue_ready when full", 0, 32'(issue_ready));
		next_cycle();
		// the ninth instruction waits on the strobe while the buffer is full
		issue_v = 1'b1;
		issue_rfw = 1'b1;
		issue_rd = 3'd7;
		issue_srw = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_value("issue_ready while held", 0, 32'(issue_ready));
			next_cycle();
		end
		complete(tags[0]);
		issue(1'b1, 3'd7, 1'b0, tags[8]);
		for (int i = 1; i < 9; i++) complete(tags[i]);
		wait_commit_total(base + 9);
		end_test();
	endtask

	task automatic flush_in_flight();
		int base;
		start_test("flush");
		base = commit_count;
		for (int i = 0; i < 4; i++) issue(1'b1, 3'(i + 4), i == 1, tags[i]);
		// younger entries finish but the head does not, so nothing retires
		complete(tags[1]);
		complete(tags[2]);
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		@(negedge clk);
		check_value("rf_v after flush", (1 << (ooo_pkg::sr_index + 1)) - 1, 32'(rf_v));
		check_value("issue_ready after flush", 1, 32'(issue_ready));
		next_cycle();
		// late done strobes name discarded entries and must be ignored
		complete(tags[0]);
		complete(tags[3]);
		repeat (4) next_cycle();
		check_value("commits after flush", 32'(base), 32'(commit_count));
		end_test();
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		int unsigned seed_ret;
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		issue_v = 1'b0;
		issue_rfw = 1'b0;
		issue_rd = '0;
		issue_srw = 1'b0;
		done_v = 1'b0;
		done_id = '0;
		seed_ret = $urandom(25);
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		after_reset();
		dispatch_clears_targets();
		random_completion();
		youngest_writer_rule();
		full_buffer_stall();
		flush_in_flight();
		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
